// ==== include/rv_defs.svh ====
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// Core widths
`define RV_XLEN		64
`define RV_ILEN		32

// Register file
`define RV_NUM_REG	32
`define RV_REG_AW	5

// Bus and boot
`define RV_ADDR_W	32
`define RV_RESET_PC	32'h8000_0000	// First fetch

`endif

// ==== hw/rv_pkg.sv ====
`include "rv_defs.svh"

package rv_pkg;

	// Major opcodes kept by the core
	typedef enum logic [6:0] {
		OPC_LOAD	= 7'b0000011,
		OPC_OP_IMM	= 7'b0010011,
		OPC_AUIPC	= 7'b0010111,
		OPC_STORE	= 7'b0100011,
		OPC_OP		= 7'b0110011,
		OPC_LUI		= 7'b0110111,
		OPC_BRANCH	= 7'b1100011,
		OPC_JALR	= 7'b1100111,
		OPC_JAL		= 7'b1101111,
		OPC_SYSTEM	= 7'b1110011
	} opcode_e;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
		ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
	} alu_op_e;

	typedef enum logic [2:0] {
		ST_FETCH, ST_DECODE, ST_EXEC, ST_MEM_LO, ST_MEM_HI, ST_WRITEBACK, ST_HALT
	} state_e;

	typedef struct packed {
		opcode_e			opcode;
		alu_op_e			alu_op;
		logic [2:0]			funct3;
		logic [`RV_REG_AW-1:0]		rd;
		logic [`RV_REG_AW-1:0]		rs1;
		logic [`RV_REG_AW-1:0]		rs2;
		logic [`RV_XLEN-1:0]		imm;	// Sign-extended
		logic				use_imm;	// Immediate as ALU operand b
		logic				is_ecall;
	} decoded_t;

endpackage

// ==== hw/rv_mem_if.sv ====
`timescale 1ns/1ps
`include "rv_defs.svh"

interface rv_mem_if;
	logic			req;
	logic			write;
	logic [`RV_ADDR_W-1:0]	addr;
	logic [`RV_ILEN-1:0]	wdata;
	logic			done;	// One cycle, ends the request
	logic [`RV_ILEN-1:0]	rdata;	// Valid with done

	modport ctrl (
		output req, write, addr, wdata,
		input  done, rdata
	);

	modport apb (
		input  req, write, addr, wdata,
		output done, rdata
	);
endinterface

// ==== hw/rv_alu.sv ====
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_alu (
	input  logic [`RV_XLEN-1:0]	a_i,
	input  logic [`RV_XLEN-1:0]	b_i,
	input  rv_pkg::alu_op_e		op_i,
	output logic [`RV_XLEN-1:0]	result_o
);
	logic [5:0]	shamt;
	logic		lt_s;
	logic		lt_u;

	assign shamt = b_i[5:0];	// RV64 shift amount
	assign lt_s  = $signed(a_i) < $signed(b_i);
	assign lt_u  = a_i < b_i;

	always_comb begin
		case (op_i)
		rv_pkg::ALU_ADD:  result_o = a_i + b_i;
		rv_pkg::ALU_SUB:  result_o = a_i - b_i;
		rv_pkg::ALU_SLL:  result_o = a_i << shamt;
		rv_pkg::ALU_SLT:  result_o = {{(`RV_XLEN-1){1'b0}}, lt_s};
		rv_pkg::ALU_SLTU: result_o = {{(`RV_XLEN-1){1'b0}}, lt_u};
		rv_pkg::ALU_XOR:  result_o = a_i ^ b_i;
		rv_pkg::ALU_SRL:  result_o = a_i >> shamt;
		rv_pkg::ALU_SRA:  result_o = $signed(a_i) >>> shamt;
		rv_pkg::ALU_OR:   result_o = a_i | b_i;
		rv_pkg::ALU_AND:  result_o = a_i & b_i;
		default:          result_o = '0;
		endcase
	end
endmodule

// ==== hw/rv_decode.sv ====
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_decode (
	input  logic [`RV_ILEN-1:0]	inst_i,
	output rv_pkg::decoded_t	dec_o
);
	rv_pkg::opcode_e	opcode;
	logic [6:0]		funct7;
	logic [`RV_ILEN-1:0]	imm32;

	assign opcode = rv_pkg::opcode_e'(inst_i[6:0]);	// Unknown values retire as nop
	assign funct7 = inst_i[31:25];

	always_comb begin
		case (opcode)
		rv_pkg::OPC_STORE:  imm32 = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
		rv_pkg::OPC_BRANCH: imm32 = {{19{inst_i[31]}}, inst_i[31], inst_i[7],
			inst_i[30:25], inst_i[11:8], 1'b0};
		rv_pkg::OPC_LUI, rv_pkg::OPC_AUIPC: imm32 = {inst_i[31:12], 12'h000};
		rv_pkg::OPC_JAL:    imm32 = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12],
			inst_i[20], inst_i[30:21], 1'b0};
		default:            imm32 = {{20{inst_i[31]}}, inst_i[31:20]};
		endcase
	end

	always_comb begin
		dec_o.opcode   = opcode;
		dec_o.funct3   = inst_i[14:12];
		dec_o.rd       = inst_i[11:7];
		dec_o.rs1      = inst_i[19:15];
		dec_o.rs2      = inst_i[24:20];
		dec_o.imm      = {{(`RV_XLEN-`RV_ILEN){imm32[`RV_ILEN-1]}}, imm32};
		dec_o.use_imm  = opcode != rv_pkg::OPC_OP;
		dec_o.is_ecall = opcode == rv_pkg::OPC_SYSTEM && inst_i[31:7] == '0;
		dec_o.alu_op   = rv_pkg::ALU_ADD;
		if (opcode == rv_pkg::OPC_OP || opcode == rv_pkg::OPC_OP_IMM) begin
			case (inst_i[14:12])
			3'b000: dec_o.alu_op = (opcode == rv_pkg::OPC_OP && funct7[5]) ?
				rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
			3'b001: dec_o.alu_op = rv_pkg::ALU_SLL;
			3'b010: dec_o.alu_op = rv_pkg::ALU_SLT;
			3'b011: dec_o.alu_op = rv_pkg::ALU_SLTU;
			3'b100: dec_o.alu_op = rv_pkg::ALU_XOR;
			3'b101: dec_o.alu_op = funct7[5] ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;	// SRAI too
			3'b110: dec_o.alu_op = rv_pkg::ALU_OR;
			default: dec_o.alu_op = rv_pkg::ALU_AND;
			endcase
		end
	end
endmodule

// ==== hw/rv_regfile.sv ====
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_regfile (
	input  logic			CLK,
	input  logic			RSTn,
	input  logic [`RV_REG_AW-1:0]	rs1_addr_i,
	input  logic [`RV_REG_AW-1:0]	rs2_addr_i,
	output logic [`RV_XLEN-1:0]	rs1_data_o,
	output logic [`RV_XLEN-1:0]	rs2_data_o,
	input  logic			we_i,
	input  logic [`RV_REG_AW-1:0]	rd_addr_i,
	input  logic [`RV_XLEN-1:0]	rd_data_i
);
	logic [`RV_XLEN-1:0]	regs [`RV_NUM_REG];

	always_ff @(posedge CLK or negedge RSTn) begin
		if (!RSTn) begin
			for (int i = 0; i < `RV_NUM_REG; i++)
				regs[i] <= '0;
		end else if (we_i && rd_addr_i != '0) begin
			regs[rd_addr_i] <= rd_data_i;
		end
	end

	// x0 reads as zero
	assign rs1_data_o = rs1_addr_i == '0 ? '0 : regs[rs1_addr_i];
	assign rs2_data_o = rs2_addr_i == '0 ? '0 : regs[rs2_addr_i];
endmodule

// ==== hw/rv_apb_master.sv ====
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_apb_master (
	input  logic			CLK,
	input  logic			RSTn,
	rv_mem_if.apb			mem,
	output logic [`RV_ADDR_W-1:0]	paddr_o,
	output logic			psel_o,
	output logic			penable_o,
	output logic			pwrite_o,
	output logic [`RV_ILEN-1:0]	pwdata_o,
	input  logic [`RV_ILEN-1:0]	prdata_i,
	input  logic			pready_i
);
	typedef enum logic [1:0] {APB_IDLE, APB_SETUP, APB_ACCESS} apb_state_e;

	apb_state_e	state;

	assign psel_o    = state != APB_IDLE;
	assign penable_o = state == APB_ACCESS;
	assign mem.done  = penable_o && pready_i;	// Last access cycle
	assign mem.rdata = prdata_i;

	always_ff @(posedge CLK or negedge RSTn) begin
		if (!RSTn) begin
			state    <= APB_IDLE;
			pwrite_o <= 1'b0;
		end else begin
			case (state)
			APB_IDLE: if (mem.req) begin
				state    <= APB_SETUP;
				pwrite_o <= mem.write;
			end
			APB_SETUP:  state <= APB_ACCESS;
			APB_ACCESS: if (pready_i) state <= APB_IDLE;	// Else wait state
			default:    state <= APB_IDLE;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (state == APB_IDLE && mem.req) begin
			paddr_o  <= mem.addr;
			pwdata_o <= mem.wdata;
		end
	end
endmodule

// ==== hw/rv_ctrl.sv ====
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_ctrl (
	input  logic			CLK,
	input  logic			RSTn,
	rv_mem_if.ctrl			mem,
	output logic [`RV_ILEN-1:0]	inst_o,
	input  rv_pkg::decoded_t	dec_i,
	input  logic [`RV_XLEN-1:0]	rs1_data_i,
	input  logic [`RV_XLEN-1:0]	rs2_data_i,
	output logic [`RV_XLEN-1:0]	alu_a_o,
	output logic [`RV_XLEN-1:0]	alu_b_o,
	output rv_pkg::alu_op_e		alu_op_o,
	input  logic [`RV_XLEN-1:0]	alu_result_i,
	output logic			rd_we_o,
	output logic [`RV_REG_AW-1:0]	rd_addr_o,
	output logic [`RV_XLEN-1:0]	rd_data_o,
	output logic			halt_o
);
	rv_pkg::state_e		state;
	logic [`RV_XLEN-1:0]	pc, pc_inc, pc_target, npc, npc_q;
	logic [`RV_XLEN-1:0]	res_q;	// ALU result, later load data
	logic [`RV_ILEN-1:0]	ir, lo_q;
	logic			req_q, mem_state, is_load, is_store, is_dword, taken, writes_rd;

	assign pc_inc    = pc + `RV_XLEN'(4);
	assign pc_target = pc + dec_i.imm;
	assign is_load   = dec_i.opcode == rv_pkg::OPC_LOAD;
	assign is_store  = dec_i.opcode == rv_pkg::OPC_STORE;
	assign is_dword  = dec_i.funct3[0];	// LD, SD
	assign mem_state = state inside {rv_pkg::ST_FETCH, rv_pkg::ST_MEM_LO, rv_pkg::ST_MEM_HI};
	assign writes_rd = dec_i.opcode inside {rv_pkg::OPC_LOAD, rv_pkg::OPC_OP, rv_pkg::OPC_OP_IMM,
		rv_pkg::OPC_LUI, rv_pkg::OPC_AUIPC, rv_pkg::OPC_JAL, rv_pkg::OPC_JALR};

	assign mem.req   = req_q;
	assign mem.write = state != rv_pkg::ST_FETCH && is_store;
	assign mem.addr  = state == rv_pkg::ST_FETCH ? pc[`RV_ADDR_W-1:0] :
		state == rv_pkg::ST_MEM_HI ? res_q[`RV_ADDR_W-1:0] + `RV_ADDR_W'(4) :
		res_q[`RV_ADDR_W-1:0];
	assign mem.wdata = state == rv_pkg::ST_MEM_HI ? rs2_data_i[`RV_XLEN-1:`RV_ILEN] :
		rs2_data_i[`RV_ILEN-1:0];

	assign inst_o    = ir;
	assign halt_o    = state == rv_pkg::ST_HALT;
	assign rd_addr_o = dec_i.rd;
	assign rd_we_o   = state == rv_pkg::ST_WRITEBACK && writes_rd && dec_i.rd != '0;

	// EQ/NE from SUB, the rest from SLT/SLTU; funct3[0] inverts
	assign taken = dec_i.funct3[2] ? (alu_result_i[0] ^ dec_i.funct3[0]) :
		((alu_result_i == '0) ^ dec_i.funct3[0]);

	always_comb begin
		alu_a_o  = rs1_data_i;
		alu_b_o  = dec_i.imm;
		alu_op_o = rv_pkg::ALU_ADD;	// Address and JALR target
		npc      = pc_inc;
		case (dec_i.opcode)
		rv_pkg::OPC_AUIPC: alu_a_o = pc;
		rv_pkg::OPC_BRANCH: begin
			alu_b_o  = rs2_data_i;
			alu_op_o = !dec_i.funct3[2] ? rv_pkg::ALU_SUB :
				dec_i.funct3[1] ? rv_pkg::ALU_SLTU : rv_pkg::ALU_SLT;
			if (taken)
				npc = pc_target;
		end
		rv_pkg::OPC_OP, rv_pkg::OPC_OP_IMM: begin
			alu_b_o  = dec_i.use_imm ? dec_i.imm : rs2_data_i;
			alu_op_o = dec_i.alu_op;
		end
		rv_pkg::OPC_JAL:  npc = pc_target;
		rv_pkg::OPC_JALR: npc = {alu_result_i[`RV_XLEN-1:1], 1'b0};
		default: ;
		endcase
	end

	always_comb begin
		case (dec_i.opcode)
		rv_pkg::OPC_LUI:                  rd_data_o = dec_i.imm;
		rv_pkg::OPC_JAL, rv_pkg::OPC_JALR: rd_data_o = pc_inc;	// Link
		default:                          rd_data_o = res_q;
		endcase
	end

	always_ff @(posedge CLK or negedge RSTn) begin
		if (!RSTn) begin
			state <= rv_pkg::ST_FETCH;
			pc    <= `RV_XLEN'(`RV_RESET_PC);
			req_q <= 1'b0;
		end else begin
			if (mem.done)
				req_q <= 1'b0;	// Gap of one cycle before the next word
			else if (mem_state)
				req_q <= 1'b1;
			case (state)
			rv_pkg::ST_FETCH:  if (mem.done) state <= rv_pkg::ST_DECODE;
			rv_pkg::ST_DECODE: state <= rv_pkg::ST_EXEC;
			rv_pkg::ST_EXEC: begin
				if (dec_i.is_ecall)
					state <= rv_pkg::ST_HALT;
				else if (is_load || is_store)
					state <= rv_pkg::ST_MEM_LO;
				else
					state <= rv_pkg::ST_WRITEBACK;
			end
			rv_pkg::ST_MEM_LO: if (mem.done) state <= is_dword ? rv_pkg::ST_MEM_HI :
				rv_pkg::ST_WRITEBACK;
			rv_pkg::ST_MEM_HI: if (mem.done) state <= rv_pkg::ST_WRITEBACK;
			rv_pkg::ST_WRITEBACK: begin
				pc    <= npc_q;
				state <= rv_pkg::ST_FETCH;
			end
			default: ;	// HALT is final
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (state == rv_pkg::ST_FETCH && mem.done)
			ir <= mem.rdata;
		if (state == rv_pkg::ST_EXEC) begin
			res_q <= alu_result_i;
			npc_q <= npc;
		end
		if (state == rv_pkg::ST_MEM_LO && mem.done) begin
			lo_q <= mem.rdata;
			if (is_load && !is_dword)	// LW sign, LWU zero
				res_q <= {{(`RV_XLEN-`RV_ILEN){mem.rdata[`RV_ILEN-1] & ~dec_i.funct3[2]}},
					mem.rdata};
		end
		if (state == rv_pkg::ST_MEM_HI && mem.done && is_load)
			res_q <= {mem.rdata, lo_q};
	end
endmodule

// ==== hw/rv_top.sv ====
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_top (
	input  logic			CLK,
	input  logic			RSTn,
	output logic [`RV_ADDR_W-1:0]	paddr_o,
	output logic			psel_o,
	output logic			penable_o,
	output logic			pwrite_o,
	output logic [`RV_ILEN-1:0]	pwdata_o,
	input  logic [`RV_ILEN-1:0]	prdata_i,
	input  logic			pready_i,
	output logic			halt_o
);
	rv_pkg::decoded_t		dec;
	rv_pkg::alu_op_e		alu_op;
	logic [`RV_ILEN-1:0]		inst;
	logic [`RV_XLEN-1:0]		rs1_data;
	logic [`RV_XLEN-1:0]		rs2_data;
	logic [`RV_XLEN-1:0]		alu_a;
	logic [`RV_XLEN-1:0]		alu_b;
	logic [`RV_XLEN-1:0]		alu_result;
	logic				rd_we;
	logic [`RV_REG_AW-1:0]		rd_addr;
	logic [`RV_XLEN-1:0]		rd_data;

	rv_mem_if mem_bus ();

	rv_ctrl u_ctrl (.CLK(CLK), .RSTn(RSTn), .mem(mem_bus.ctrl), .inst_o(inst), .dec_i(dec),
		.rs1_data_i(rs1_data), .rs2_data_i(rs2_data), .alu_a_o(alu_a), .alu_b_o(alu_b),
		.alu_op_o(alu_op), .alu_result_i(alu_result), .rd_we_o(rd_we),
		.rd_addr_o(rd_addr), .rd_data_o(rd_data), .halt_o(halt_o));

	rv_decode u_decode (.inst_i(inst), .dec_o(dec));

	rv_regfile u_regfile (.CLK(CLK), .RSTn(RSTn), .rs1_addr_i(dec.rs1),
		.rs2_addr_i(dec.rs2), .rs1_data_o(rs1_data), .rs2_data_o(rs2_data),
		.we_i(rd_we), .rd_addr_i(rd_addr), .rd_data_i(rd_data));

	rv_alu u_alu (.a_i(alu_a), .b_i(alu_b), .op_i(alu_op), .result_o(alu_result));

	rv_apb_master u_apb (.CLK(CLK), .RSTn(RSTn), .mem(mem_bus.apb), .paddr_o(paddr_o),
		.psel_o(psel_o), .penable_o(penable_o), .pwrite_o(pwrite_o),
		.pwdata_o(pwdata_o), .prdata_i(prdata_i), .pready_i(pready_i));
endmodule

// ==== tests/rv_properties.sv ====
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_properties (
	input logic			CLK,
	input logic			RSTn,
	input logic [`RV_ADDR_W-1:0]	paddr_o,
	input logic			psel_o,
	input logic			penable_o,
	input logic			pwrite_o,
	input logic [`RV_ILEN-1:0]	pwdata_o,
	input logic			pready_i,
	input logic			halt_o
);
	int	fail_count = 0;	// Failed assertions so far

	a_setup_first: assert property (@(posedge CLK) disable iff (!RSTn)
		$rose(psel_o) |-> !penable_o)
		else begin
			$error("psel_o rose together with penable_o");
			fail_count++;
		end

	a_enable_next: assert property (@(posedge CLK) disable iff (!RSTn)
		psel_o && !penable_o |=> psel_o && penable_o)
		else begin
			$error("penable_o did not follow the setup cycle");
			fail_count++;
		end

	a_stable_wait: assert property (@(posedge CLK) disable iff (!RSTn)
		psel_o && penable_o && !pready_i |=>
		$stable(paddr_o) && $stable(pwrite_o) && $stable(pwdata_o))
		else begin
			$error("APB address or data changed during a wait state");
			fail_count++;
		end

	// Halted core stays quiet
	a_halt_quiet: assert property (@(posedge CLK) disable iff (!RSTn)
		halt_o |-> !psel_o ##1 halt_o)
		else begin
			$error("APB activity or halt drop after halt");
			fail_count++;
		end
endmodule

bind rv_top rv_properties u_props (.CLK(CLK), .RSTn(RSTn), .paddr_o(paddr_o),
	.psel_o(psel_o), .penable_o(penable_o), .pwrite_o(pwrite_o), .pwdata_o(pwdata_o),
	.pready_i(pready_i), .halt_o(halt_o));

// ==== tests/tb_rv_top.sv ====
`timescale 1ns/1ps
`include "rv_defs.svh"

module tb_rv_top;
	localparam int MEM_WORDS = 4096;
	localparam int BODY_LEN  = 48;
	localparam int PROG_LEN  = 96;
	localparam int NUM_TESTS = 5;
	localparam logic [31:0] DATA_BASE = 32'h8000_2000;	// Loads and stores live above

	logic			CLK;
	logic			RSTn;
	logic [`RV_ADDR_W-1:0]	paddr_o;
	logic			psel_o, penable_o, pwrite_o, pready_i, halt_o;
	logic [`RV_ILEN-1:0]	pwdata_o, prdata_i;

	logic [31:0]	mem [MEM_WORDS];
	logic [31:0]	ref_mem [MEM_WORDS];
	logic [63:0]	xr [32];
	logic [31:0]	exp_fetch [$];
	logic [31:0]	act_fetch [$];
	logic [63:0]	exp_store [$];	// {addr, data}
	logic [63:0]	act_store [$];
	integer		seed;
	int		errors, passed, failed, wait_left;
	bit		wait_en;

	rv_top dut (.CLK(CLK), .RSTn(RSTn), .paddr_o(paddr_o), .psel_o(psel_o),
		.penable_o(penable_o), .pwrite_o(pwrite_o), .pwdata_o(pwdata_o),
		.prdata_i(prdata_i), .pready_i(pready_i), .halt_o(halt_o));

	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	function automatic int rnd(int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	function automatic int min_int(int a, int b);
		return a < b ? a : b;
	endfunction

	function automatic int word_index(logic [31:0] a);
		return int'(((a - `RV_RESET_PC) >> 2) & 32'hfff);
	endfunction

	function automatic logic [31:0] fill_word(logic [31:0] a);
		return a ^ {a[15:0], a[31:16]} ^ 32'h5a5a_c3c3;
	endfunction

	function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
		logic [2:0] f3, logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] enc_i(logic [6:0] op, logic [4:0] rd, logic [2:0] f3,
		logic [4:0] rs1, logic [11:0] imm);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] enc_s(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
		logic [11:0] imm);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] enc_b(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
		logic [12:0] off);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] enc_u(logic [6:0] op, logic [4:0] rd, logic [19:0] imm);
		return {imm, rd, op};
	endfunction

	function automatic logic [31:0] enc_j(logic [4:0] rd, logic [20:0] off);
		return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
	endfunction

	function automatic logic [63:0] alu_ref(logic [63:0] a, logic [63:0] b, logic [2:0] f3,
		bit alt);
		logic [63:0] r;
		case (f3)
		3'd0: r = alt ? a - b : a + b;
		3'd1: r = a << b[5:0];
		3'd2: r = {63'd0, $signed(a) < $signed(b)};
		3'd3: r = {63'd0, a < b};
		3'd4: r = a ^ b;
		3'd5: begin
			if (alt)
				r = $signed(a) >>> b[5:0];
			else
				r = a >> b[5:0];
		end
		3'd6: r = a | b;
		default: r = a & b;
		endcase
		return r;
	endfunction

	function automatic bit branch_ref(logic [63:0] a, logic [63:0] b, logic [2:0] f3);
		case (f3)
		3'd0: return a == b;
		3'd1: return a != b;
		3'd4: return $signed(a) < $signed(b);
		3'd5: return $signed(a) >= $signed(b);
		3'd6: return a < b;
		3'd7: return a >= b;
		default: return 1'b0;
		endcase
	endfunction

	// Body of random instructions, then SD of x1..x31 and ECALL
	task automatic gen_program(bit ctrl_en, bit mem_en);
		int		i, k, tgt, f3;
		bit		dw;
		bit		targeted [PROG_LEN];
		logic [4:0]	rd;
		logic [5:0]	sh;
		logic [11:0]	imm;
		logic [31:0]	taddr, hi;
		for (i = 0; i < MEM_WORDS; i++)
			mem[i] = fill_word(`RV_RESET_PC + 32'(i * 4));
		for (i = 0; i < PROG_LEN; i++)
			targeted[i] = 1'b0;
		mem[0] = enc_u(7'b0110111, 5'd31, DATA_BASE[31:12]);	// x31 is the data base
		i = 1;
		while (i < BODY_LEN) begin
			k  = rnd(10);
			rd = 5'(1 + rnd(30));
			f3 = rnd(8);
			sh = 6'(rnd(64));
			dw = rnd(2) == 1;
			if (ctrl_en && k == 4 && f3 != 2 && f3 != 3) begin
				tgt = min_int(i + 1 + rnd(4), BODY_LEN);
				targeted[tgt] = 1'b1;
				mem[i] = enc_b(3'(f3), 5'(rnd(32)), 5'(rnd(32)), 13'((tgt - i) * 4));
			end else if (ctrl_en && k == 5) begin
				tgt = min_int(i + 1 + rnd(4), BODY_LEN);
				targeted[tgt] = 1'b1;
				mem[i] = enc_j(rd, 21'((tgt - i) * 4));
			end else if (ctrl_en && k == 6 && i + 3 < BODY_LEN && !targeted[i + 1] &&
				!targeted[i + 2]) begin
				tgt = min_int(i + 3 + rnd(4), BODY_LEN);	// LUI/ADDI/JALR triple
				targeted[tgt] = 1'b1;
				taddr = `RV_RESET_PC + 32'(tgt * 4);
				hi = (taddr + 32'h800) >> 12;
				mem[i] = enc_u(7'b0110111, 5'd30, hi[19:0]);
				mem[i + 1] = enc_i(7'b0010011, 5'd30, 3'b000, 5'd30, 12'(taddr - (hi << 12)));
				mem[i + 2] = enc_i(7'b1100111, rd, 3'b000, 5'd30, 12'd0);
				i += 2;
			end else if (mem_en && k >= 7) begin
				imm = 12'(8 * rnd(64) + (dw ? 0 : 4 * rnd(2)));
				if (k == 7)
					mem[i] = enc_s(dw ? 3'b011 : 3'b010, 5'd31, 5'(rnd(32)), imm);
				else
					mem[i] = enc_i(7'b0000011, rd, dw ? 3'b011 : 3'b010, 5'd31, imm);
			end else begin
				case (k % 4)
				0: mem[i] = enc_r(((f3 == 0 || f3 == 5) && dw) ? 7'h20 : 7'h00,
					5'(rnd(32)), 5'(rnd(32)), 3'(f3), rd);
				1: begin
					if (f3 == 1)
						imm = {6'd0, sh};
					else if (f3 == 5)
						imm = {1'b0, dw, 4'd0, sh};	// SRAI when dw
					else
						imm = 12'(rnd(4096));
					mem[i] = enc_i(7'b0010011, rd, 3'(f3), 5'(rnd(32)), imm);
				end
				2: mem[i] = enc_u(7'b0110111, rd, 20'(rnd(1 << 20)));
				default: mem[i] = enc_u(7'b0010111, rd, 20'(rnd(1 << 20)));
				endcase
			end
			i++;
		end
		for (k = 1; k < 32; k++)
			mem[BODY_LEN + k - 1] = enc_s(3'b011, 5'd31, 5'(k), 12'(1024 + 8 * k));
		mem[BODY_LEN + 31] = 32'h0000_0073;	// ECALL
		for (i = 0; i < MEM_WORDS; i++)
			ref_mem[i] = mem[i];
	endtask

	task automatic store_ref(logic [31:0] a, logic [31:0] d);
		exp_store.push_back({a, d});
		ref_mem[word_index(a)] = d;
	endtask

	// Instruction-set model that records fetch addresses and stores
	task automatic run_model();
		logic [63:0]	pc, npc, a, b, res, immi, imms, immb, immu, immj;
		logic [31:0]	w, ad;
		logic [4:0]	rd;
		logic [2:0]	f3;
		bit		wr;
		int		steps;
		exp_fetch.delete();
		exp_store.delete();
		for (int r = 0; r < 32; r++)
			xr[r] = '0;
		pc = 64'(`RV_RESET_PC);
		for (steps = 0; steps < PROG_LEN * 2; steps++) begin
			exp_fetch.push_back(pc[31:0]);
			w    = ref_mem[word_index(pc[31:0])];
			rd   = w[11:7];
			f3   = w[14:12];
			a    = xr[w[19:15]];
			b    = xr[w[24:20]];
			immi = {{52{w[31]}}, w[31:20]};
			imms = {{52{w[31]}}, w[31:25], w[11:7]};
			immb = {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
			immu = {{32{w[31]}}, w[31:12], 12'h000};
			immj = {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
			res  = '0;
			wr   = 1'b1;
			npc  = pc + 64'd4;
			case (w[6:0])
			7'b0110011: res = alu_ref(a, b, f3, w[30]);
			7'b0010011: res = alu_ref(a, immi, f3, f3 == 3'd5 && w[30]);
			7'b0110111: res = immu;
			7'b0010111: res = pc + immu;
			7'b1101111: begin
				res = pc + 64'd4;
				npc = pc + immj;
			end
			7'b1100111: begin
				res = pc + 64'd4;
				npc = (a + immi) & ~64'd1;
			end
			7'b1100011: begin
				wr = 1'b0;
				if (branch_ref(a, b, f3))
					npc = pc + immb;
			end
			7'b0000011: begin
				ad = 32'(a + immi);
				if (f3 == 3'b011)
					res = {ref_mem[word_index(ad + 4)], ref_mem[word_index(ad)]};
				else
					res = {{32{ref_mem[word_index(ad)][31]}}, ref_mem[word_index(ad)]};
			end
			7'b0100011: begin
				wr = 1'b0;
				ad = 32'(a + imms);
				store_ref(ad, b[31:0]);
				if (f3 == 3'b011)
					store_ref(ad + 4, b[63:32]);
			end
			7'b1110011: if (w[31:7] == '0) return;
			default: wr = 1'b0;	// Unknown opcode is a nop
			endcase
			if (wr && rd != 5'd0)
				xr[rd] = res;
			pc = npc;
		end
	endtask

	// APB memory with random wait states
	always @(posedge CLK) begin
		if (!RSTn) begin
			pready_i <= 1'b0;
		end else if (psel_o && !penable_o) begin
			assert (paddr_o >= `RV_RESET_PC && paddr_o < DATA_BASE + 32'h2000)
			else begin
				$display("APB access outside the memory at %0t, address %h", $time, paddr_o);
				errors++;
			end
			wait_left = wait_en ? rnd(4) : 0;
			pready_i <= wait_left == 0;
			prdata_i <= mem[word_index(paddr_o)];
		end else if (psel_o && pready_i) begin
			if (pwrite_o) begin
				mem[word_index(paddr_o)] = pwdata_o;
				act_store.push_back({paddr_o, pwdata_o});
			end else if (paddr_o < DATA_BASE) begin
				act_fetch.push_back(paddr_o);
			end
			pready_i <= 1'b0;
		end else if (psel_o) begin
			wait_left--;
			pready_i <= wait_left == 0;
		end
	end

	task automatic compare_val(string what, logic [63:0] got, logic [63:0] exp);
		assert (got === exp)
		else begin
			$display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic run_dut(bit waits);
		wait_en = waits;
		act_fetch.delete();
		act_store.delete();
		@(posedge CLK);
		RSTn <= 1'b0;
		repeat (2) @(posedge CLK);
		RSTn <= 1'b1;
		@(posedge CLK);
		compare_val("halt_o after reset", 64'(halt_o), 64'd0);
		while (!halt_o)
			@(posedge CLK);
		repeat (50) begin
			@(posedge CLK);
			compare_val("halt_o and psel_o after halt", {halt_o, psel_o}, 64'b10);
		end
	endtask

	task automatic compare_results();
		compare_val("first fetch", act_fetch.size() > 0 ? act_fetch[0] : 'x, `RV_RESET_PC);
		compare_val("fetch count", act_fetch.size(), exp_fetch.size());
		for (int i = 0; i < min_int(act_fetch.size(), exp_fetch.size()); i++)
			compare_val("fetch address", act_fetch[i], exp_fetch[i]);
		compare_val("store count", act_store.size(), exp_store.size());
		for (int i = 0; i < min_int(act_store.size(), exp_store.size()); i++)
			compare_val("store addr/data", act_store[i], exp_store[i]);
	endtask

	initial begin
		string	names [NUM_TESTS];
		int	e0;
		int	p0;
		names = '{"alu", "control", "memory", "mixed_no_wait", "mixed_wait"};
		seed     = 32'hf266;
		RSTn     = 1'b0;
		pready_i = 1'b0;
		prdata_i = '0;
		wait_en  = 1'b0;
		errors   = 0;
		passed   = 0;
		failed   = 0;
		for (int t = 0; t < NUM_TESTS; t++) begin
			e0 = errors;
			p0 = dut.u_props.fail_count;
			gen_program(t == 1 || t >= 3, t >= 2);
			run_model();
			run_dut(t != 3);
			compare_results();
			assert (dut.u_props.fail_count == p0)
			else begin
				$display("Bound APB or halt assertions failed %0d times at %0t",
					dut.u_props.fail_count - p0, $time);
				errors++;
			end
			if (errors == e0) begin
				passed++;
				$display("Test %s: pass", names[t]);
			end else begin
				failed++;
				$display("Test %s: FAIL (%0d errors)", names[t], errors - e0);
			end
		end
		$display("Tests run %0d, passed %0d, failed %0d", NUM_TESTS, passed, failed);
		if (failed == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

	// Watchdog
	initial begin
		repeat (NUM_TESTS * PROG_LEN * 40) @(posedge CLK);
		$display("Timeout: the run did not finish within %0d cycles",
			NUM_TESTS * PROG_LEN * 40);
		$display("Some tests failed");
		$finish;
	end
endmodule

// ==== src.f ====
+incdir+include
hw/rv_pkg.sv
hw/rv_mem_if.sv
hw/rv_alu.sv
hw/rv_decode.sv
hw/rv_regfile.sv
hw/rv_apb_master.sv
hw/rv_ctrl.sv
hw/rv_top.sv
tests/rv_properties.sv
tests/tb_rv_top.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tb_rv_top -Mdir obj_dir
	./obj_dir/Vtb_rv_top | tee sim.log
	@if grep -q "Some tests failed" sim.log; then echo "FAIL"; exit 1; fi
	@grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
